// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module asg_tb \
  -f verilog.f -o asg_sim || exit 1
out=$(./obj_dir/asg_sim 2>&1)
echo "$out"
echo "$out" | grep -q "Testbench passed" && exit 0 || exit 1

// ==== sim/asg_props.sv ====
`timescale 1ns/1ps

`include "asg_cfg.svh"

module asg_props import asg_pkg::*; (
  input logic                                clk,
  input logic                                ctl_rst,
  input asg_bus_rsp_t                        bus_rsp,
  input logic                                trg_o,
  input asg_smp_t                            dac,
  input logic                                dac_credit,
  // sender credit count inside the credit transmitter
  input logic [$clog2(`ASG_CREDITS + 1)-1:0] crd_cnt
);

  //////////////////////////////////////////////////////////////////////
  // credit rules
  //////////////////////////////////////////////////////////////////////

  // count moves by returns minus sends, so it never climbs past the grant
  credit_max: assert property (
    @(posedge clk) disable iff (ctl_rst)
    1'b1 |=> (int'(crd_cnt) == int'($past(crd_cnt)) + int'($past(dac_credit)) -
              int'($past(dac.vld)))
  ) else $error("credit count off its send and return balance");

  // out of credits means no sample
  no_send_dry: assert property (
    @(posedge clk) disable iff (ctl_rst) (crd_cnt == '0) |-> !dac.vld
  ) else $error("sample sent while no credit was held");

  //////////////////////////////////////////////////////////////////////
  // reset rules
  //////////////////////////////////////////////////////////////////////

  // outputs quiet right after reset
  rst_quiet: assert property (
    @(posedge clk) ctl_rst |=> (!dac.vld && !trg_o && !bus_rsp.rvld)
  ) else $error("output high in the cycle after reset");

  // full grant after reset
  rst_credits: assert property (
    @(posedge clk) ctl_rst |=> (crd_cnt == `ASG_CREDITS)
  ) else $error("credit count not restored by reset");

  //////////////////////////////////////////////////////////////////////
  // trigger rules
  //////////////////////////////////////////////////////////////////////

  trg_single: assert property (
    @(posedge clk) disable iff (ctl_rst) trg_o |=> !trg_o
  ) else $error("trigger out high for two cycles in a row");

endmodule

// ==== sim/asg_tb.sv ====
`timescale 1ns/1ps

`include "asg_cfg.svh"

module asg_tb import asg_pkg::*; ();

  localparam int          TBL_N     = 64;
  localparam logic [31:0] LFSR_SEED = 32'hdef2_3b34;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic         clk = 1'b0;
  logic         ctl_rst;
  asg_bus_req_t bus_req;
  asg_bus_rsp_t bus_rsp;
  logic         trg_i;
  logic         trg_o;
  asg_smp_t     dac;
  logic         dac_credit = 1'b0;

  // separate streams for stimulus and credit gaps
  logic [31:0] lfsr_stim = LFSR_SEED;
  logic [31:0] lfsr_gap = LFSR_SEED;

  // table contents as written over the bus
  logic signed [`ASG_DW-1:0] tbl_model [0:2**`ASG_CWM-1];

  // config as the model sees it
  logic [`ASG_PW-1:0] m_size;
  logic [`ASG_PW-1:0] m_step;
  logic [`ASG_PW-1:0] m_offs;
  logic               m_bena;
  logic [15:0]        m_bcyc;

  // reference pointer state
  logic [`ASG_PW-1:0] ref_ptr;
  int                 burst_pos = 0;

  int   n_smp = 0;
  int   n_trg = 0;
  int   errors = 0;
  int   n_tests = 0;
  int   n_failed = 0;
  int   cyc = 0;
  int   trg_cyc = 0;
  int   first_cyc = 0;
  logic first_wait = 1'b0;
  logic timed_out = 1'b0;
  // pending credit returns, cycles left for each
  int   gap_q[$];

  asg_top dut0 (
    .clk        (clk),
    .ctl_rst    (ctl_rst),
    .bus_req    (bus_req),
    .bus_rsp    (bus_rsp),
    .trg_i      (trg_i),
    .trg_o      (trg_o),
    .dac        (dac),
    .dac_credit (dac_credit)
  );

  bind asg_top asg_props props0 (
    .clk        (clk),
    .ctl_rst    (ctl_rst),
    .bus_rsp    (bus_rsp),
    .trg_o      (trg_o),
    .dac        (dac),
    .dac_credit (dac_credit),
    .crd_cnt    (ctx0.crd_cnt)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  // galois lfsr, one step per bit
  function automatic logic [31:0] take_bits(inout logic [31:0] st, input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      st = st[0] ? ((st >> 1) ^ LFSR_TAPS) : (st >> 1);
      v = {v[30:0], st[0]};
    end
    return v;
  endfunction

  // add step, wrap by size plus one once past size
  function automatic logic [`ASG_PW-1:0] next_ptr(input logic [`ASG_PW-1:0] p);
    logic [31:0] sum;
    sum = 32'(p) + 32'(m_step);
    if (sum > 32'(m_size)) begin
      sum = sum - 32'(m_size) - 32'd1;
    end
    return sum[`ASG_PW-1:0];
  endfunction

  // readable field bits per register
  function automatic logic [31:0] reg_mask(input int r);
    case (r)
      0, 1, 2: return (32'd1 << `ASG_PW) - 32'd1;
      3:       return 32'h0000_0003;
      4, 6:    return 32'h0000_ffff;
      default: return 32'hffff_ffff;
    endcase
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp) else begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic bus_write(input logic [15:0] addr, input logic [31:0] data);
    @(posedge clk);
    bus_req <= '{ena: 1'b1, wen: 1'b1, addr: addr, wdata: data};
    @(posedge clk);
    bus_req.ena <= 1'b0;
  endtask

  // response sampled mid cycle, one cycle after the request
  task automatic bus_read(input logic [15:0] addr, output logic [31:0] data);
    @(posedge clk);
    bus_req <= '{ena: 1'b1, wen: 1'b0, addr: addr, wdata: 32'd0};
    @(posedge clk);
    bus_req.ena <= 1'b0;
    @(negedge clk);
    assert (bus_rsp.rvld) else begin
      errors++;
      $display("read valid missing one cycle after the read of address %h", addr);
    end
    data = bus_rsp.rdata;
  endtask

  task automatic pulse_trg();
    @(posedge clk);
    trg_i <= 1'b1;
    trg_cyc = cyc;
    @(posedge clk);
    trg_i <= 1'b0;
  endtask

  // model restarts from offs together with the trigger
  task automatic start_run();
    ref_ptr = m_offs;
    burst_pos = 0;
    first_wait = 1'b1;
    pulse_trg();
  endtask

  task automatic setup_chan(input int size_n, input logic [31:0] step,
                            input logic [31:0] offs, input logic [2:0] bctl,
                            input logic [15:0] bcyc, input logic [31:0] bdly,
                            input logic [15:0] bnum);
    m_size = `ASG_PW'((size_n << `ASG_CWF) - 1);
    m_step = step[`ASG_PW-1:0];
    m_offs = offs[`ASG_PW-1:0];
    m_bena = bctl[0];
    m_bcyc = bcyc;
    bus_write(16'(ASG_REG_SIZE), 32'(m_size));
    bus_write(16'(ASG_REG_STEP), step);
    bus_write(16'(ASG_REG_OFFS), offs);
    bus_write(16'(ASG_REG_BCYC), 32'(bcyc));
    bus_write(16'(ASG_REG_BDLY), bdly);
    bus_write(16'(ASG_REG_BNUM), 32'(bnum));
    bus_write(16'(ASG_REG_BCTL), 32'(bctl));
  endtask

  task automatic wait_samples(input int target, input int limit, input string what);
    int i;
    i = 0;
    while (n_smp < target && i < limit && !timed_out) begin
      @(negedge clk);
      i++;
    end
    if (n_smp < target && !timed_out) begin
      timed_out = 1'b1;
      errors++;
      $display("timed out waiting for %s", what);
    end
  endtask

  // output counts as stopped after span idle cycles
  task automatic wait_quiet(input int span, input int limit);
    int i;
    int calm;
    i = 0;
    calm = 0;
    while (calm < span && i < limit && !timed_out) begin
      @(negedge clk);
      calm = dac.vld ? 0 : calm + 1;
      i++;
    end
    if (calm < span && !timed_out) begin
      timed_out = 1'b1;
      errors++;
      $display("sample output did not stop");
    end
  endtask

  task automatic report_test(input int num, input string name, input int err0);
    n_tests++;
    if (errors == err0) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      n_failed++;
      $display("test %0d %s: %0d errors", num, name, errors - err0);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // dac model and sample checker
  //////////////////////////////////////////////////////////////////////

  // one credit back per sample, 0 to 3 cycles of gap
  always @(posedge clk) begin
    if (ctl_rst) begin
      dac_credit <= 1'b0;
      gap_q.delete();
    end else begin
      dac_credit <= 1'b0;
      if (gap_q.size() != 0) begin
        if (gap_q[0] == 0) begin
          dac_credit <= 1'b1;
          void'(gap_q.pop_front());
        end else begin
          gap_q[0] = gap_q[0] - 1;
        end
      end
      if (dac.vld) begin
        gap_q.push_back(int'(take_bits(lfsr_gap, 2)));
      end
    end
  end

  // each sample against the entry at the pointer magnitude
  always @(posedge clk) begin
    if (!ctl_rst && trg_o) begin
      n_trg++;
    end
    if (!ctl_rst && dac.vld) begin
      if (first_wait) begin
        first_cyc = cyc;
        first_wait = 1'b0;
      end
      check_eq("dac.dat", 32'(dac.dat), 32'(tbl_model[ref_ptr[`ASG_CWF +: `ASG_CWM]]));
      n_smp++;
      // burst end reloads offs
      if (m_bena && burst_pos == int'(m_bcyc)) begin
        burst_pos = 0;
        ref_ptr = m_offs;
      end else begin
        burst_pos++;
        ref_ptr = next_ptr(ref_ptr);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task automatic regs_test();
    int          err0;
    logic [31:0] wval;
    logic [31:0] rval;
    err0 = errors;
    for (int r = 0; r < 7; r++) begin
      wval = take_bits(lfsr_stim, 32);
      bus_write(16'(r), wval);
      bus_read(16'(r), rval);
      check_eq($sformatf("bus_rsp.rdata reg %0d", r), rval, wval & reg_mask(r));
    end
    report_test(1, "register readback", err0);
  endtask

  task automatic table_test();
    int          err0;
    logic [31:0] v;
    logic [31:0] rval;
    err0 = errors;
    for (int i = 0; i < TBL_N; i++) begin
      v = take_bits(lfsr_stim, `ASG_DW);
      tbl_model[i] = v[`ASG_DW-1:0];
      bus_write(16'h8000 | 16'(i), v);
    end
    // sign extended on the way back
    for (int i = 0; i < TBL_N; i++) begin
      bus_read(16'h8000 | 16'(i), rval);
      check_eq($sformatf("bus_rsp.rdata tbl %0d", i), rval, 32'(tbl_model[i]));
    end
    report_test(2, "table readback", err0);
  endtask

  task automatic cont_test();
    int err0;
    int base;
    err0 = errors;
    // 37 entries, step 1.75, offs 5.5
    setup_chan(37, 32'h0001_c000, 32'h0005_8000, 3'b000, 16'd0, 32'd0, 16'd0);
    base = n_smp;
    start_run();
    wait_samples(base + 100, 3000, "continuous samples");
    assert (first_wait || (first_cyc - trg_cyc) >= 4) else begin
      errors++;
      $display("first sample only %0d cycles after the trigger", first_cyc - trg_cyc);
    end
    bus_write(16'(ASG_REG_BCTL), 32'h4);
    wait_quiet(24, 400);
    report_test(3, "continuous mode", err0);
  endtask

  task automatic burst_test();
    int err0;
    int base;
    int tbase;
    err0 = errors;
    // 3 bursts of 6 samples with 8 delay cycles
    setup_chan(20, 32'h0000_8000, 32'h0003_4000, 3'b001, 16'd5, 32'd8, 16'd3);
    base = n_smp;
    tbase = n_trg;
    start_run();
    wait_samples(base + 18, 2000, "burst samples");
    wait_quiet(40, 600);
    check_eq("burst sample count", 32'(n_smp - base), 32'd18);
    check_eq("trg_o pulses", 32'(n_trg - tbase), 32'd3);
    // endless bursts run past bnum
    bus_write(16'(ASG_REG_BCTL), 32'h3);
    base = n_smp;
    tbase = n_trg;
    start_run();
    wait_samples(base + 30, 3000, "endless burst samples");
    bus_write(16'(ASG_REG_BCTL), 32'h4);
    wait_quiet(40, 600);
    assert (n_trg - tbase > 3) else begin
      errors++;
      $display("endless burst mode stopped after the repetition count");
    end
    report_test(4, "burst mode", err0);
  endtask

  task automatic clear_test();
    int err0;
    int base;
    int tbase;
    err0 = errors;
    // 50 entries, step about 3.3, offs 7.25
    setup_chan(50, 32'h0003_4ccc, 32'h0007_4000, 3'b000, 16'd0, 32'd0, 16'd0);
    base = n_smp;
    start_run();
    wait_samples(base + 10, 1000, "samples before the extra trigger");
    // ignored while running, model keeps going
    tbase = n_trg;
    pulse_trg();
    wait_samples(base + 30, 1000, "samples after the extra trigger");
    check_eq("trg_o pulses", 32'(n_trg - tbase), 32'd0);
    bus_write(16'(ASG_REG_BCTL), 32'h4);
    wait_quiet(24, 400);
    // restart from offs
    base = n_smp;
    start_run();
    wait_samples(base + 10, 1000, "samples after the restart");
    bus_write(16'(ASG_REG_BCTL), 32'h4);
    wait_quiet(24, 400);
    report_test(5, "clear and trigger", err0);
  endtask

  initial begin
    ctl_rst = 1'b1;
    bus_req = '0;
    trg_i = 1'b0;
    repeat (4) @(posedge clk);
    ctl_rst <= 1'b0;
    regs_test();
    table_test();
    if (!timed_out) begin
      cont_test();
    end
    if (!timed_out) begin
      burst_test();
    end
    if (!timed_out) begin
      clear_test();
    end
    $display("tests run %0d, tests failed %0d, checks failed %0d", n_tests, n_failed, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+verilog
verilog/asg_pkg.sv
verilog/asg_regs.sv
verilog/asg_chan.sv
verilog/asg_credit_tx.sv
verilog/asg_top.sv
sim/asg_props.sv
sim/asg_tb.sv

// ==== verilog/asg_cfg.svh ====
`ifndef ASG_CFG_SVH
`define ASG_CFG_SVH

// table address width, pointer magnitude
`define ASG_CWM 10

// pointer fraction width
`define ASG_CWF 16

// full fixed point pointer width
`define ASG_PW (`ASG_CWM + `ASG_CWF)

// signed sample width toward the DAC
`define ASG_DW 14

// output sample queue depth
`define ASG_QDEPTH 4

// credits held by the sender after reset
`define ASG_CREDITS 3

`endif

// ==== verilog/asg_chan.sv ====
`timescale 1ns/1ps

`include "asg_cfg.svh"

module asg_chan import asg_pkg::*; (
  input  logic                      clk,
  input  logic                      ctl_rst,
  input  asg_cfg_t                  cfg,
  input  asg_tbl_req_t              tbl_req,
  output logic signed [`ASG_DW-1:0] tbl_rdata,
  input  logic                      trg_i,
  output logic                      trg_o,
  input  logic                      adv,
  output asg_smp_t                  smp
);

  //////////////////////////////////////////////////////////////////////
  // waveform table
  //////////////////////////////////////////////////////////////////////

  logic signed [`ASG_DW-1:0] tbl_mem [0:2**`ASG_CWM-1];

  // stream side read pipeline
  logic                      p1_vld;
  logic [`ASG_CWM-1:0]       p1_addr;
  logic                      p2_vld;
  logic signed [`ASG_DW-1:0] p2_dat;

  // cpu write
  always_ff @(posedge clk) begin
    if (tbl_req.ena & tbl_req.wen) begin
      tbl_mem[tbl_req.addr] <= tbl_req.wdata;
    end
  end

  // cpu readback, one cycle latency
  always_ff @(posedge clk) begin
    if (tbl_req.ena & ~tbl_req.wen) begin
      tbl_rdata <= tbl_mem[tbl_req.addr];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // state machine and counters
  //////////////////////////////////////////////////////////////////////

  asg_sts_t            sts;
  logic [`ASG_PW-1:0]  ptr_cur;
  // two spare bits keep the sign of the wrap test clean
  logic [`ASG_PW+1:0]  ptr_sum;
  logic [`ASG_PW+1:0]  ptr_sub;
  logic [`ASG_PW-1:0]  ptr_nxt;
  logic [15:0]         cnt_cyc;
  logic [31:0]         cnt_dly;
  logic [15:0]         cnt_rep;
  logic                launch;
  logic                start;
  logic                bend;
  logic                again;

  // one table read per adv cycle in data state
  assign launch = (sts == STS_DATA) & adv;

  // trigger only counts when idle
  assign start = trg_i & (sts == STS_IDLE) & ~cfg.clr;

  // end of one burst, after its last sample or last delay cycle
  assign bend = cfg.bena & ~cfg.clr &
                (((sts == STS_DATA) & launch & (cnt_cyc == '0) & (cnt_dly == '0)) |
                 ((sts == STS_DELAY) & adv & (cnt_dly == 32'd1)));

  // more bursts to go
  assign again = bend & (cfg.binf | (cnt_rep > 16'd1));

  // modulo step, wrap by size plus one
  assign ptr_sum = {2'b00, ptr_cur} + {2'b00, cfg.step};
  assign ptr_sub = ptr_sum - {2'b00, cfg.size} - 1'b1;
  assign ptr_nxt = ptr_sub[`ASG_PW+1] ? ptr_sum[`ASG_PW-1:0] : ptr_sub[`ASG_PW-1:0];

  always_ff @(posedge clk) begin
    if (ctl_rst | cfg.clr) begin
      sts     <= STS_IDLE;
      ptr_cur <= '0;
      cnt_cyc <= '0;
      cnt_dly <= '0;
      cnt_rep <= '0;
    end else if (start) begin
      sts     <= STS_DATA;
      ptr_cur <= cfg.offs;
      cnt_cyc <= cfg.bcyc;
      cnt_dly <= cfg.bdly;
      cnt_rep <= cfg.bnum;
    end else if (bend) begin
      if (again) begin
        // restart from offs for the next burst
        sts     <= STS_DATA;
        ptr_cur <= cfg.offs;
        cnt_cyc <= cfg.bcyc;
        cnt_dly <= cfg.bdly;
        if (cnt_rep != '0) begin
          cnt_rep <= cnt_rep - 1'b1;
        end
      end else begin
        sts     <= STS_IDLE;
        cnt_rep <= '0;
      end
    end else begin
      if (launch) begin
        ptr_cur <= ptr_nxt;
      end
      // burst counting, frozen while adv is low
      if (cfg.bena) begin
        if (launch & (cnt_cyc != '0)) begin
          cnt_cyc <= cnt_cyc - 1'b1;
        end
        if (launch & (cnt_cyc == '0)) begin
          sts <= STS_DELAY;
        end
        if ((sts == STS_DELAY) & adv) begin
          cnt_dly <= cnt_dly - 1'b1;
        end
      end
    end
  end

  // trigger notification, one cycle after start or restart
  always_ff @(posedge clk) begin
    if (ctl_rst) begin
      trg_o <= 1'b0;
    end else begin
      trg_o <= start | again;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // table read pipeline
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (ctl_rst) begin
      p1_vld <= 1'b0;
      p2_vld <= 1'b0;
    end else begin
      p1_vld <= launch;
      p2_vld <= p1_vld;
    end
  end

  // address stage, magnitude only
  always_ff @(posedge clk) begin
    if (launch) begin
      p1_addr <= ptr_cur[`ASG_CWF +: `ASG_CWM];
    end
  end

  // data stage
  always_ff @(posedge clk) begin
    if (p1_vld) begin
      p2_dat <= tbl_mem[p1_addr];
    end
  end

  assign smp.vld = p2_vld;
  assign smp.dat = p2_dat;

endmodule

// ==== verilog/asg_credit_tx.sv ====
`timescale 1ns/1ps

`include "asg_cfg.svh"

module asg_credit_tx import asg_pkg::*; (
  input  logic     clk,
  input  logic     ctl_rst,
  input  asg_smp_t smp,
  output logic     adv,
  output asg_smp_t dac,
  input  logic     dac_credit
);

  localparam int unsigned QAW = $clog2(`ASG_QDEPTH);
  localparam int unsigned CW  = $clog2(`ASG_CREDITS + 1);

  //////////////////////////////////////////////////////////////////////
  // sample queue
  //////////////////////////////////////////////////////////////////////

  logic signed [`ASG_DW-1:0] q_mem [0:`ASG_QDEPTH-1];
  logic [QAW-1:0]            wr_ptr;
  logic [QAW-1:0]            rd_ptr;
  logic [QAW:0]              q_cnt;
  logic [QAW:0]              q_free;
  logic [QAW:0]              fly;
  logic [CW-1:0]             crd_cnt;
  logic                      adv_q;
  logic                      pop;

  // head leaves when there is a sample and a credit
  assign pop = (q_cnt != '0) & (crd_cnt != '0);

  always_ff @(posedge clk) begin
    if (smp.vld) begin
      q_mem[wr_ptr] <= smp.dat;
    end
  end

  always_ff @(posedge clk) begin
    if (ctl_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      q_cnt  <= '0;
    end else begin
      if (smp.vld) begin
        wr_ptr <= (wr_ptr == QAW'(`ASG_QDEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == QAW'(`ASG_QDEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({smp.vld, pop})
        2'b10:   q_cnt <= q_cnt + 1'b1;
        2'b01:   q_cnt <= q_cnt - 1'b1;
        default: q_cnt <= q_cnt;
      endcase
    end
  end

  assign dac.vld = pop;
  assign dac.dat = q_mem[rd_ptr];

  //////////////////////////////////////////////////////////////////////
  // credits and advance permission
  //////////////////////////////////////////////////////////////////////

  // send and return together cancel out
  always_ff @(posedge clk) begin
    if (ctl_rst) begin
      crd_cnt <= CW'(`ASG_CREDITS);
    end else begin
      case ({pop, dac_credit})
        2'b10: crd_cnt <= crd_cnt - 1'b1;
        2'b01: begin
          if (crd_cnt != CW'(`ASG_CREDITS)) begin
            crd_cnt <= crd_cnt + 1'b1;
          end
        end
        default: crd_cnt <= crd_cnt;
      endcase
    end
  end

  // last adv may have launched a read into the address stage
  always_ff @(posedge clk) begin
    if (ctl_rst) begin
      adv_q <= 1'b0;
    end else begin
      adv_q <= adv;
    end
  end

  // in flight: address stage bound plus the data stage
  assign fly    = (QAW+1)'(adv_q) + (QAW+1)'(smp.vld);
  assign q_free = (QAW+1)'(`ASG_QDEPTH) - q_cnt;
  assign adv    = q_free > (fly + 1'b1);

endmodule

// ==== verilog/asg_pkg.sv ====
`include "asg_cfg.svh"

package asg_pkg;

  // register index in addr[3:0]
  localparam logic [3:0] ASG_REG_SIZE = 4'd0;
  localparam logic [3:0] ASG_REG_STEP = 4'd1;
  localparam logic [3:0] ASG_REG_OFFS = 4'd2;
  // bit 0 bena, bit 1 binf, bit 2 clr
  localparam logic [3:0] ASG_REG_BCTL = 4'd3;
  localparam logic [3:0] ASG_REG_BCYC = 4'd4;
  localparam logic [3:0] ASG_REG_BDLY = 4'd5;
  localparam logic [3:0] ASG_REG_BNUM = 4'd6;

  // cpu bus, addr[15] picks the table
  typedef struct packed {
    logic        ena;
    logic        wen;
    logic [15:0] addr;
    logic [31:0] wdata;
  } asg_bus_req_t;

  typedef struct packed {
    logic        rvld;
    logic [31:0] rdata;
  } asg_bus_rsp_t;

  // channel configuration
  typedef struct packed {
    logic [`ASG_PW-1:0] size;
    logic [`ASG_PW-1:0] step;
    logic [`ASG_PW-1:0] offs;
    logic               bena;
    logic               binf;
    logic [15:0]        bcyc;
    logic [31:0]        bdly;
    logic [15:0]        bnum;
    // one cycle software clear
    logic               clr;
  } asg_cfg_t;

  // table port from the decoder
  typedef struct packed {
    logic                      ena;
    logic                      wen;
    logic [`ASG_CWM-1:0]       addr;
    logic signed [`ASG_DW-1:0] wdata;
  } asg_tbl_req_t;

  typedef enum logic [1:0] {
    STS_IDLE  = 2'd0,
    STS_DATA  = 2'd1,
    STS_DELAY = 2'd2
  } asg_sts_t;

  // sample stream, also the DAC port
  typedef struct packed {
    logic                      vld;
    logic signed [`ASG_DW-1:0] dat;
  } asg_smp_t;

endpackage

// ==== verilog/asg_regs.sv ====
`timescale 1ns/1ps

`include "asg_cfg.svh"

module asg_regs import asg_pkg::*; (
  input  logic                      clk,
  input  logic                      ctl_rst,
  input  asg_bus_req_t              bus_req,
  output asg_bus_rsp_t              bus_rsp,
  output asg_cfg_t                  cfg,
  output asg_tbl_req_t              tbl_req,
  input  logic signed [`ASG_DW-1:0] tbl_rdata
);

  //////////////////////////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////////////////////////

  logic       sel_tbl;
  logic [3:0] idx;
  logic       reg_we;
  logic       rd_req;

  assign sel_tbl = bus_req.addr[15];
  assign idx     = bus_req.addr[3:0];
  assign reg_we  = bus_req.ena & bus_req.wen & ~sel_tbl;
  // reads of either space
  assign rd_req  = bus_req.ena & ~bus_req.wen;

  // table accesses pass straight to the channel
  assign tbl_req.ena   = bus_req.ena & sel_tbl;
  assign tbl_req.wen   = bus_req.wen;
  assign tbl_req.addr  = bus_req.addr[`ASG_CWM-1:0];
  assign tbl_req.wdata = bus_req.wdata[`ASG_DW-1:0];

  //////////////////////////////////////////////////////////////////////
  // configuration registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (ctl_rst) begin
      cfg <= '0;
    end else begin
      // clr only lives for one cycle
      cfg.clr <= 1'b0;
      if (reg_we) begin
        case (idx)
          ASG_REG_SIZE: cfg.size <= bus_req.wdata[`ASG_PW-1:0];
          ASG_REG_STEP: cfg.step <= bus_req.wdata[`ASG_PW-1:0];
          ASG_REG_OFFS: cfg.offs <= bus_req.wdata[`ASG_PW-1:0];
          ASG_REG_BCTL: begin
            cfg.bena <= bus_req.wdata[0];
            cfg.binf <= bus_req.wdata[1];
            cfg.clr  <= bus_req.wdata[2];
          end
          ASG_REG_BCYC: cfg.bcyc <= bus_req.wdata[15:0];
          ASG_REG_BDLY: cfg.bdly <= bus_req.wdata;
          ASG_REG_BNUM: cfg.bnum <= bus_req.wdata[15:0];
          default: ;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read response
  //////////////////////////////////////////////////////////////////////

  logic        rd_vld;
  logic        rd_tbl;
  logic [3:0]  rd_idx;
  logic [31:0] reg_val;

  // selector held for the response cycle
  always_ff @(posedge clk) begin
    if (ctl_rst) begin
      rd_vld <= 1'b0;
      rd_tbl <= 1'b0;
      rd_idx <= '0;
    end else begin
      rd_vld <= rd_req;
      if (rd_req) begin
        rd_tbl <= sel_tbl;
        rd_idx <= idx;
      end
    end
  end

  // register readback, zero extended
  always_comb begin
    reg_val = '0;
    case (rd_idx)
      ASG_REG_SIZE: reg_val[`ASG_PW-1:0] = cfg.size;
      ASG_REG_STEP: reg_val[`ASG_PW-1:0] = cfg.step;
      ASG_REG_OFFS: reg_val[`ASG_PW-1:0] = cfg.offs;
      // clr always reads as zero
      ASG_REG_BCTL: reg_val[1:0] = {cfg.binf, cfg.bena};
      ASG_REG_BCYC: reg_val[15:0] = cfg.bcyc;
      ASG_REG_BDLY: reg_val = cfg.bdly;
      ASG_REG_BNUM: reg_val[15:0] = cfg.bnum;
      default: reg_val = '0;
    endcase
  end

  assign bus_rsp.rvld  = rd_vld;
  // table data arrives this cycle, sign extended
  assign bus_rsp.rdata = rd_tbl ? {{(32-`ASG_DW){tbl_rdata[`ASG_DW-1]}}, tbl_rdata}
                                : reg_val;

endmodule

// ==== verilog/asg_top.sv ====
`timescale 1ns/1ps

`include "asg_cfg.svh"

module asg_top import asg_pkg::*; (
  input  logic         clk,
  input  logic         ctl_rst,
  // cpu port
  input  asg_bus_req_t bus_req,
  output asg_bus_rsp_t bus_rsp,
  // triggers
  input  logic         trg_i,
  output logic         trg_o,
  // dac stream, one credit back per sample
  output asg_smp_t     dac,
  input  logic         dac_credit
);

  //////////////////////////////////////////////////////////////////////
  // internal wiring
  //////////////////////////////////////////////////////////////////////

  asg_cfg_t                  cfg;
  asg_tbl_req_t              tbl_req;
  logic signed [`ASG_DW-1:0] tbl_rdata;
  asg_smp_t                  smp;
  logic                      adv;

  // bus decode and config registers
  asg_regs regs0 (
    .clk       (clk),
    .ctl_rst   (ctl_rst),
    .bus_req   (bus_req),
    .bus_rsp   (bus_rsp),
    .cfg       (cfg),
    .tbl_req   (tbl_req),
    .tbl_rdata (tbl_rdata)
  );

  // table, pointer and burst fsm
  asg_chan chan0 (
    .clk       (clk),
    .ctl_rst   (ctl_rst),
    .cfg       (cfg),
    .tbl_req   (tbl_req),
    .tbl_rdata (tbl_rdata),
    .trg_i     (trg_i),
    .trg_o     (trg_o),
    .adv       (adv),
    .smp       (smp)
  );

  // queue and credit pacing toward the dac
  asg_credit_tx ctx0 (
    .clk        (clk),
    .ctl_rst    (ctl_rst),
    .smp        (smp),
    .adv        (adv),
    .dac        (dac),
    .dac_credit (dac_credit)
  );

endmodule
